/* list.f */
design/csi2_pkg.sv
design/camera_pkg.sv
design/camera_ifs.sv
design/csi2_packet_parser.sv
design/raw10_unpacker.sv
design/exposure_metering.sv
design/frame_writer.sv
design/frame_buffer.sv
design/command_port.sv
design/camera_top.sv
dv/camera_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the camera front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module camera_tb \
    -Mdir obj_dir \
    -o camera_sim

# Exit status of the simulation is the result
./obj_dir/camera_sim

/* dv/camera_tb.sv */
// ------------------------------
// Camera front end testbench
// Table-driven frames and host commands
// against a reference image model
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module camera_tb;
    import csi2_pkg::*;
    import camera_pkg::*;

    typedef struct packed {
        logic       arm;
        logic       foreign;
        logic [7:0] reads;
        logic [7:0] frame_count;
    } step_t;

    localparam int          NUM_STEPS   = 6;
    localparam int          STEP_CYCLES = 3000;    // One frame with idles plus commands
    localparam logic [5:0]  FOREIGN_DT  = 6'h12;   // Embedded data type
    localparam logic [31:0] SEED        = 32'had92d5d7;
    localparam step_t       STEPS [NUM_STEPS] = '{
        '{1'b0, 1'b0, 8'd0,  8'd1},
        '{1'b1, 1'b0, 8'd8,  8'd2},
        '{1'b0, 1'b1, 8'd8,  8'd3},
        '{1'b1, 1'b1, 8'd12, 8'd4},
        '{1'b0, 1'b0, 8'd6,  8'd5},
        '{1'b1, 1'b0, 8'd16, 8'd6}
    };

    logic       mipi_byte_clock;
    logic       mipi_byte_reset_n;
    logic       byte_valid_i;
    logic [7:0] byte_data_i;
    logic       cmd_valid_i;
    logic [7:0] cmd_opcode_i;
    logic [7:0] cmd_operand_i;
    logic       resp_valid_o;
    logic [7:0] resp_data_o;

    logic [9:0] frame_pixels [FRAME_PIXELS];
    logic [7:0] image_bytes  [FRAME_PIXELS];   // Last captured frame
    logic       have_image;
    int         pixels_sent;                   // Pixels generated in the current frame

    camera_top DUT (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .byte_valid_i      (byte_valid_i),
        .byte_data_i       (byte_data_i),
        .cmd_valid_i       (cmd_valid_i),
        .cmd_opcode_i      (cmd_opcode_i),
        .cmd_operand_i     (cmd_operand_i),
        .resp_valid_o      (resp_valid_o),
        .resp_data_o       (resp_data_o)
    );

    initial begin
        mipi_byte_clock = 1'b0;
        forever #5 mipi_byte_clock = ~mipi_byte_clock;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped after a failure");
    endtask

    task automatic check_byte(input string what, input logic [7:0] got,
                              input logic [7:0] expected);
        assert (got === expected) else
            stop_run($sformatf("** Error at %0t: %s returned %02h, expected %02h",
                               $time, what, got, expected));
    endtask

    function automatic logic [7:0] status_value(input logic ready, input logic busy);
        logic [7:0] value;
        value                   = '0;
        value[STATUS_READY_BIT] = ready;
        value[STATUS_BUSY_BIT]  = busy;
        return value;
    endfunction

    task automatic send_byte(input logic [7:0] value);
        int idle;
        idle = $urandom_range(0, 2);
        repeat (idle) begin
            @(posedge mipi_byte_clock);
            byte_valid_i <= 1'b0;
        end
        @(posedge mipi_byte_clock);
        byte_valid_i <= 1'b1;
        byte_data_i  <= value;
    endtask

    task automatic send_header(input logic [5:0] data_type, input logic [15:0] word_count);
        send_byte({2'($urandom), data_type});   // Random virtual channel
        send_byte(word_count[7:0]);
        send_byte(word_count[15:8]);
        send_byte(8'($urandom));                // Dummy ECC
    endtask

    task automatic send_foreign_packet();
        send_header(FOREIGN_DT, 16'd6);
        repeat (8) send_byte(8'($urandom));    // Payload and CRC
    endtask

    task automatic send_frame(input logic foreign);
        logic [7:0] lsb_byte;
        int         idx;
        pixels_sent = 0;
        send_header(DT_FRAME_START, 16'd0);
        for (int line = 0; line < FRAME_HEIGHT; line++) begin
            if (foreign && line == FRAME_HEIGHT / 2)
                send_foreign_packet();
            send_header(DT_RAW10, 16'(FRAME_WIDTH * 10 / 8));
            for (int g = 0; g < FRAME_WIDTH / 4; g++) begin
                lsb_byte = '0;
                for (int k = 0; k < 4; k++) begin
                    idx                = line * FRAME_WIDTH + g * 4 + k;
                    frame_pixels[idx]  = 10'($urandom);
                    pixels_sent        = idx + 1;
                    lsb_byte[2*k +: 2] = frame_pixels[idx][1:0];
                    send_byte(frame_pixels[idx][9:2]);
                end
                send_byte(lsb_byte);
            end
            send_byte(8'($urandom));            // Dummy CRC
            send_byte(8'($urandom));
        end
        send_header(DT_FRAME_END, 16'd0);
        @(posedge mipi_byte_clock);
        byte_valid_i <= 1'b0;
    endtask

    task automatic send_command(input logic [7:0] opcode, input logic [7:0] operand,
                                output logic [7:0] data);
        int waited;
        @(posedge mipi_byte_clock);
        cmd_valid_i   <= 1'b1;
        cmd_opcode_i  <= opcode;
        cmd_operand_i <= operand;
        @(posedge mipi_byte_clock);
        cmd_valid_i <= 1'b0;
        waited = 0;
        @(negedge mipi_byte_clock);
        while (!resp_valid_o) begin
            waited++;
            if (waited > 8)
                stop_run($sformatf("No response to opcode %02h within 8 cycles", opcode));
            @(negedge mipi_byte_clock);
        end
        data = resp_data_o;
    endtask

    task automatic arm_capture();
        @(posedge mipi_byte_clock);
        cmd_valid_i  <= 1'b1;
        cmd_opcode_i <= OP_CAPTURE;
        @(posedge mipi_byte_clock);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic expect_response(input string what, input logic [7:0] opcode,
                                   input logic [7:0] expected);
        logic [7:0] data;
        send_command(opcode, 8'h00, data);
        check_byte(what, data, expected);
    endtask

    task automatic read_random_pixels(input int count, input logic during_capture);
        logic [7:0] data;
        logic [7:0] old_byte;
        int         idx;
        repeat (count) begin
            idx      = $urandom_range(0, FRAME_PIXELS - 1);
            old_byte = image_bytes[idx];
            send_command(OP_READ_BYTE, 8'(idx), data);
            if (during_capture && idx < pixels_sent && data !== old_byte)   // Word rewritten
                check_byte("OP_READ_BYTE during capture", data, frame_pixels[idx][9:2]);
            else
                check_byte("OP_READ_BYTE", data, old_byte);
            repeat ($urandom_range(0, 20)) @(posedge mipi_byte_clock);
        end
    endtask

    initial begin
        repeat ((NUM_STEPS + 1) * STEP_CYCLES) @(posedge mipi_byte_clock);
        stop_run("Timeout: the test table did not complete in the expected time");
    end

    initial begin
        logic [7:0] data;
        logic [7:0] last_count;
        int         sum;
        int         polls;
        void'($urandom(SEED));
        $timeformat(-9, 0, " ns", 0);
        mipi_byte_reset_n = 1'b0;
        byte_valid_i      = 1'b0;
        byte_data_i       = '0;
        cmd_valid_i       = 1'b0;
        cmd_opcode_i      = '0;
        cmd_operand_i     = '0;
        have_image        = 1'b0;
        pixels_sent       = 0;
        last_count        = '0;
        repeat (2) @(posedge mipi_byte_clock);
        mipi_byte_reset_n <= 1'b1;

        expect_response("OP_STATUS after reset", OP_STATUS, status_value(1'b0, 1'b0));
        expect_response("OP_FRAME_COUNT after reset", OP_FRAME_COUNT, 8'h00);
        expect_response("Unknown opcode", 8'h7E, BAD_OPCODE_RESPONSE);

        for (int s = 0; s < NUM_STEPS; s++) begin
            if (STEPS[s].arm) begin
                arm_capture();
                expect_response("OP_STATUS after arm", OP_STATUS, status_value(1'b0, 1'b1));
            end
            fork
                send_frame(STEPS[s].foreign);
                if (have_image)
                    read_random_pixels(STEPS[s].reads, STEPS[s].arm);
            join
            sum = 0;
            for (int i = 0; i < FRAME_PIXELS; i++)
                sum += frame_pixels[i];
            if (STEPS[s].arm) begin
                for (int i = 0; i < FRAME_PIXELS; i++)
                    image_bytes[i] = frame_pixels[i][9:2];
                have_image = 1'b1;
            end
            polls = 0;
            do begin   // Frame count moves once metering is done
                send_command(OP_FRAME_COUNT, 8'h00, data);
                polls++;
                if (polls > 20)
                    stop_run("Frame count did not advance after a frame was sent");
            end while (data == last_count);
            check_byte("OP_FRAME_COUNT", data, STEPS[s].frame_count);
            last_count = data;
            expect_response("OP_METERING", OP_METERING, 8'((sum >> PIXEL_SHIFT) >> 2));
            expect_response("OP_STATUS after frame", OP_STATUS, status_value(have_image, 1'b0));
            if (have_image)
                read_random_pixels(STEPS[s].reads, 1'b0);
        end

        expect_response("Unknown opcode", 8'hA5, BAD_OPCODE_RESPONSE);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* design/camera_top.sv */
// ------------------------------
// Camera capture front end
// CSI-2 byte stream in, host commands out
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module camera_top (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,
    input  logic       byte_valid_i,
    input  logic [7:0] byte_data_i,
    input  logic       cmd_valid_i,
    input  logic [7:0] cmd_opcode_i,
    input  logic [7:0] cmd_operand_i,
    output logic       resp_valid_o,
    output logic [7:0] resp_data_o
);

    logic       payload_valid;
    logic [7:0] payload_byte;
    logic       frame_start;
    logic       frame_end;
    logic       capture_arm;
    logic       image_ready;
    logic       capture_busy;
    logic [7:0] meter_average;
    logic       meter_done;

    pixel_group_if pixel_bus ();
    buffer_port_if writer_bus ();
    buffer_port_if reader_bus ();

    csi2_packet_parser packet_parser (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .byte_valid_i      (byte_valid_i),
        .byte_data_i       (byte_data_i),
        .payload_valid_o   (payload_valid),
        .payload_byte_o    (payload_byte),
        .frame_start_o     (frame_start),
        .frame_end_o       (frame_end)
    );

    raw10_unpacker unpacker (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .payload_valid_i   (payload_valid),
        .payload_byte_i    (payload_byte),
        .frame_start_i     (frame_start),
        .frame_end_i       (frame_end),
        .pixels            (pixel_bus.source)
    );

    exposure_metering metering (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixels            (pixel_bus.sink),
        .meter_average_o   (meter_average),
        .meter_done_o      (meter_done)
    );

    frame_writer writer (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixels            (pixel_bus.sink),
        .capture_arm_i     (capture_arm),
        .buffer            (writer_bus.client),
        .image_ready_o     (image_ready),
        .capture_busy_o    (capture_busy)
    );

    frame_buffer buffer (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .writer            (writer_bus.arbiter),
        .reader            (reader_bus.arbiter)
    );

    command_port commands (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .cmd_valid_i       (cmd_valid_i),
        .cmd_opcode_i      (cmd_opcode_i),
        .cmd_operand_i     (cmd_operand_i),
        .resp_valid_o      (resp_valid_o),
        .resp_data_o       (resp_data_o),
        .capture_arm_o     (capture_arm),
        .buffer            (reader_bus.client),
        .image_ready_i     (image_ready),
        .capture_busy_i    (capture_busy),
        .meter_average_i   (meter_average),
        .meter_done_i      (meter_done)
    );

endmodule

`default_nettype wire

/* design/command_port.sv */
// ------------------------------
// Host command port
// Decodes opcodes, answers status, metering,
// frame count and buffer byte reads
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module command_port (
    input  logic          mipi_byte_clock,
    input  logic          mipi_byte_reset_n,
    input  logic          cmd_valid_i,
    input  logic [7:0]    cmd_opcode_i,
    input  logic [7:0]    cmd_operand_i,
    output logic          resp_valid_o,
    output logic [7:0]    resp_data_o,
    output logic          capture_arm_o,
    buffer_port_if.client buffer,
    input  logic          image_ready_i,
    input  logic          capture_busy_i,
    input  logic [7:0]    meter_average_i,
    input  logic          meter_done_i
);
    import camera_pkg::*;

    command_opcode_t opcode;
    logic [7:0]      frame_count;
    logic [7:0]      meter_value;
    logic [7:0]      status_byte;
    logic [7:0]      resp_data_q;
    logic [7:0]      lane_byte;
    logic            resp_valid_q;
    logic            read_wait;
    logic            read_busy;
    logic [1:0]      read_lane;

    assign opcode    = command_opcode_t'(cmd_opcode_i);
    assign read_busy = buffer.req | read_wait;   // Commands dropped meanwhile

    assign buffer.we    = 1'b0;
    assign buffer.wdata = '0;

    always_comb begin
        status_byte                   = '0;
        status_byte[STATUS_READY_BIT] = image_ready_i;
        status_byte[STATUS_BUSY_BIT]  = capture_busy_i;
    end

    // Read data is answered straight from the buffer register
    assign lane_byte    = buffer.rdata[8*read_lane +: 8];
    assign resp_valid_o = resp_valid_q | read_wait;
    assign resp_data_o  = read_wait ? lane_byte : resp_data_q;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_count   <= '0;
            meter_value   <= '0;
            resp_valid_q  <= 1'b0;
            resp_data_q   <= '0;
            capture_arm_o <= 1'b0;
            read_wait     <= 1'b0;
            read_lane     <= '0;
            buffer.req    <= 1'b0;
            buffer.addr   <= '0;
        end else begin
            resp_valid_q  <= 1'b0;
            capture_arm_o <= 1'b0;
            read_wait     <= buffer.req & buffer.grant;
            if (meter_done_i) begin
                frame_count <= frame_count + 8'd1;
                meter_value <= meter_average_i;
            end
            if (buffer.req && buffer.grant)
                buffer.req <= 1'b0;
            if (cmd_valid_i && !read_busy) begin
                case (opcode)
                    OP_STATUS: begin
                        resp_valid_q <= 1'b1;
                        resp_data_q  <= status_byte;
                    end
                    OP_METERING: begin
                        resp_valid_q <= 1'b1;
                        resp_data_q  <= meter_value;
                    end
                    OP_FRAME_COUNT: begin
                        resp_valid_q <= 1'b1;
                        resp_data_q  <= frame_count;
                    end
                    OP_READ_BYTE: begin
                        buffer.req  <= 1'b1;
                        buffer.addr <= cmd_operand_i[BUFFER_ADDR_W+1:2];
                        read_lane   <= cmd_operand_i[1:0];
                    end
                    OP_CAPTURE: capture_arm_o <= 1'b1;   // No response
                    default: begin
                        resp_valid_q <= 1'b1;
                        resp_data_q  <= BAD_OPCODE_RESPONSE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* design/frame_buffer.sv */
// ------------------------------
// Frame buffer
// Word memory shared by two clients
// with priority for the writer port
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  logic           mipi_byte_clock,
    input  logic           mipi_byte_reset_n,
    buffer_port_if.arbiter writer,
    buffer_port_if.arbiter reader
);
    import camera_pkg::*;

    logic [31:0]              mem [BUFFER_WORDS];
    logic                     access;
    logic                     sel_writer;
    logic                     sel_we;
    logic [BUFFER_ADDR_W-1:0] sel_addr;
    logic [31:0]              sel_wdata;
    logic [31:0]              read_data;

    assign sel_writer   = writer.req;
    assign access       = writer.req | reader.req;
    assign writer.grant = writer.req;
    assign reader.grant = reader.req & ~writer.req;

    assign sel_we    = sel_writer ? writer.we    : reader.we;
    assign sel_addr  = sel_writer ? writer.addr  : reader.addr;
    assign sel_wdata = sel_writer ? writer.wdata : reader.wdata;

    always_ff @(posedge mipi_byte_clock) begin
        if (access && sel_we)
            mem[sel_addr] <= sel_wdata;
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n)
            read_data <= '0;
        else if (access && !sel_we)
            read_data <= mem[sel_addr];
    end

    assign writer.rdata = read_data;
    assign reader.rdata = read_data;

endmodule

`default_nettype wire

/* design/frame_writer.sv */
// ------------------------------
// Frame writer
// Stores the armed frame, one word per group
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module frame_writer (
    input  logic          mipi_byte_clock,
    input  logic          mipi_byte_reset_n,
    pixel_group_if.sink   pixels,
    input  logic          capture_arm_i,
    buffer_port_if.client buffer,
    output logic          image_ready_o,
    output logic          capture_busy_o
);
    import camera_pkg::*;

    logic                     capture_pending;
    logic                     capture_active;
    logic [BUFFER_ADDR_W-1:0] word_addr;
    logic [31:0]              group_word;

    always_comb begin
        for (int k = 0; k < GROUP_PIXELS; k++)
            group_word[8*k +: 8] = pixels.pixel[k][PIXEL_W-1 -: 8];   // Lane k
    end

    assign buffer.we      = 1'b1;
    assign buffer.addr    = word_addr;
    assign capture_busy_o = capture_pending | capture_active;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            capture_pending <= 1'b0;
            capture_active  <= 1'b0;
            image_ready_o   <= 1'b0;
            word_addr       <= '0;
            buffer.req      <= 1'b0;
        end else begin
            if (capture_arm_i) begin
                image_ready_o   <= 1'b0;
                capture_pending <= 1'b1;
            end
            if (pixels.frame_start && capture_pending) begin
                capture_pending <= 1'b0;
                capture_active  <= 1'b1;
                word_addr       <= '0;
            end
            if (pixels.frame_end && capture_active) begin
                capture_active <= 1'b0;
                image_ready_o  <= 1'b1;
            end
            if (buffer.req && buffer.grant) begin
                buffer.req <= 1'b0;
                word_addr  <= word_addr + 1'b1;
            end
            if (pixels.group_valid && capture_active)
                buffer.req <= 1'b1;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (pixels.group_valid && capture_active)
            buffer.wdata <= group_word;
    end

endmodule

`default_nettype wire

/* design/exposure_metering.sv */
// ------------------------------
// Exposure metering
// Average brightness of each frame
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module exposure_metering (
    input  logic        mipi_byte_clock,
    input  logic        mipi_byte_reset_n,
    pixel_group_if.sink pixels,
    output logic [7:0]  meter_average_o,
    output logic        meter_done_o
);
    import camera_pkg::*;

    logic [PIXEL_W+PIXEL_SHIFT-1:0] accumulator;
    logic [PIXEL_W+1:0]             group_sum;
    logic [PIXEL_W-1:0]             frame_mean;

    always_comb begin
        group_sum = '0;
        for (int k = 0; k < GROUP_PIXELS; k++)
            group_sum = group_sum + {2'b00, pixels.pixel[k]};
    end

    assign frame_mean = accumulator[PIXEL_SHIFT +: PIXEL_W];   // Sum over pixel count

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            accumulator     <= '0;
            meter_average_o <= '0;
            meter_done_o    <= 1'b0;
        end else begin
            meter_done_o <= 1'b0;
            if (pixels.frame_start)
                accumulator <= '0;
            else if (pixels.group_valid)
                accumulator <= accumulator + group_sum;
            if (pixels.frame_end) begin
                meter_average_o <= frame_mean[PIXEL_W-1 -: 8];
                meter_done_o    <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/raw10_unpacker.sv */
// ------------------------------
// RAW10 unpacker
// Five payload bytes to four 10-bit pixels
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module raw10_unpacker (
    input  logic          mipi_byte_clock,
    input  logic          mipi_byte_reset_n,
    input  logic          payload_valid_i,
    input  logic [7:0]    payload_byte_i,
    input  logic          frame_start_i,
    input  logic          frame_end_i,
    pixel_group_if.source pixels
);
    import camera_pkg::*;

    logic [2:0]                  byte_phase;
    logic [GROUP_PIXELS-1:0][7:0] msb_bytes;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            byte_phase         <= '0;
            pixels.group_valid <= 1'b0;
            pixels.frame_start <= 1'b0;
            pixels.frame_end   <= 1'b0;
        end else begin
            pixels.group_valid <= 1'b0;
            pixels.frame_start <= frame_start_i;   // Kept in step with pixels
            pixels.frame_end   <= frame_end_i;
            if (frame_start_i) begin
                byte_phase <= '0;
            end else if (payload_valid_i) begin
                if (byte_phase == GROUP_PIXELS) begin   // LSB byte
                    byte_phase         <= '0;
                    pixels.group_valid <= 1'b1;
                end else begin
                    byte_phase <= byte_phase + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (payload_valid_i) begin
            if (byte_phase == GROUP_PIXELS) begin
                for (int k = 0; k < GROUP_PIXELS; k++)
                    pixels.pixel[k] <= {msb_bytes[k], payload_byte_i[2*k +: 2]};
            end else begin
                msb_bytes[byte_phase[1:0]] <= payload_byte_i;
            end
        end
    end

endmodule

`default_nettype wire

/* design/csi2_packet_parser.sv */
// ------------------------------
// CSI-2 packet parser
// Decodes headers, strobes RAW10 payload bytes
// and flags frame start and end
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module csi2_packet_parser (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,
    input  logic       byte_valid_i,
    input  logic [7:0] byte_data_i,
    output logic       payload_valid_o,
    output logic [7:0] payload_byte_o,
    output logic       frame_start_o,
    output logic       frame_end_o
);
    import csi2_pkg::*;

    parser_state_t state;
    logic [15:0]   byte_count;
    logic [15:0]   word_count;
    logic [5:0]    data_type;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state           <= HEADER;
            byte_count      <= '0;
            word_count      <= '0;
            data_type       <= '0;
            payload_valid_o <= 1'b0;
            frame_start_o   <= 1'b0;
            frame_end_o     <= 1'b0;
        end else begin
            payload_valid_o <= 1'b0;
            frame_start_o   <= 1'b0;
            frame_end_o     <= 1'b0;
            if (byte_valid_i) begin
                byte_count <= byte_count + 16'd1;
                unique case (state)
                    HEADER: begin
                        if (byte_count == HDR_DI_BYTE)
                            data_type <= byte_data_i[5:0];   // VC bits dropped
                        if (byte_count == HDR_WC_LO_BYTE)
                            word_count[7:0] <= byte_data_i;
                        if (byte_count == HDR_WC_HI_BYTE)
                            word_count[15:8] <= byte_data_i;
                        if (byte_count == HEADER_BYTES - 1) begin   // ECC byte
                            byte_count <= '0;
                            if (data_type < LONG_PACKET_MIN_DT) begin
                                frame_start_o <= (data_type == DT_FRAME_START);
                                frame_end_o   <= (data_type == DT_FRAME_END);
                            end else if (word_count == '0) begin
                                state <= FOOTER;
                            end else begin
                                state <= PAYLOAD;
                            end
                        end
                    end
                    PAYLOAD: begin
                        payload_valid_o <= (data_type == DT_RAW10);   // Others skipped
                        if (byte_count == word_count - 16'd1) begin
                            byte_count <= '0;
                            state      <= FOOTER;
                        end
                    end
                    FOOTER: begin
                        if (byte_count == FOOTER_BYTES - 1) begin
                            byte_count <= '0;
                            state      <= HEADER;
                        end
                    end
                    default: state <= HEADER;
                endcase
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (byte_valid_i && state == PAYLOAD)
            payload_byte_o <= byte_data_i;
    end

endmodule

`default_nettype wire

/* design/camera_ifs.sv */
// ------------------------------
// Camera interfaces
// Pixel group stream and frame buffer port
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

interface pixel_group_if;
    import camera_pkg::*;

    logic                                  group_valid;
    logic [GROUP_PIXELS-1:0][PIXEL_W-1:0]  pixel;
    logic                                  frame_start;
    logic                                  frame_end;

    modport source (output group_valid, pixel, frame_start, frame_end);
    modport sink   (input  group_valid, pixel, frame_start, frame_end);
endinterface

interface buffer_port_if;
    import camera_pkg::*;

    logic                     req;
    logic                     we;
    logic [BUFFER_ADDR_W-1:0] addr;
    logic [31:0]              wdata;
    logic                     grant;   // Same cycle as req
    logic [31:0]              rdata;   // One cycle after a granted read

    modport client  (output req, we, addr, wdata, input  grant, rdata);
    modport arbiter (input  req, we, addr, wdata, output grant, rdata);
endinterface

`default_nettype wire

/* design/camera_pkg.sv */
// ------------------------------
// Camera definitions
// Frame geometry, buffer size and host commands
// ------------------------------
`default_nettype none

package camera_pkg;

    localparam int FRAME_WIDTH   = 16;
    localparam int FRAME_HEIGHT  = 8;
    localparam int FRAME_PIXELS  = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int PIXEL_SHIFT   = $clog2(FRAME_PIXELS);
    localparam int PIXEL_W       = 10;
    localparam int GROUP_PIXELS  = 4;    // RAW10 packs four pixels in five bytes

    localparam int BUFFER_WORDS  = FRAME_PIXELS / GROUP_PIXELS;
    localparam int BUFFER_ADDR_W = $clog2(BUFFER_WORDS);

    typedef enum logic [7:0] {
        OP_STATUS      = 8'h10,
        OP_METERING    = 8'h11,
        OP_READ_BYTE   = 8'h12,
        OP_FRAME_COUNT = 8'h13,
        OP_CAPTURE     = 8'h20
    } command_opcode_t;

    localparam int STATUS_READY_BIT = 0;
    localparam int STATUS_BUSY_BIT  = 1;

    localparam logic [7:0] BAD_OPCODE_RESPONSE = 8'hFF;

endpackage

`default_nettype wire

/* design/csi2_pkg.sv */
// ------------------------------
// CSI-2 packet definitions
// Data types, header layout and parser states
// ------------------------------
`default_nettype none

package csi2_pkg;

    typedef enum logic [5:0] {
        DT_FRAME_START = 6'h00,
        DT_FRAME_END   = 6'h01,
        DT_RAW10       = 6'h2B
    } csi2_data_type_t;

    typedef enum logic [1:0] {
        HEADER,
        PAYLOAD,
        FOOTER
    } parser_state_t;

    localparam int HEADER_BYTES   = 4;   // DI, WC low, WC high, ECC
    localparam int HDR_DI_BYTE    = 0;
    localparam int HDR_WC_LO_BYTE = 1;
    localparam int HDR_WC_HI_BYTE = 2;
    localparam int FOOTER_BYTES   = 2;   // Unchecked CRC bytes

    localparam logic [5:0] LONG_PACKET_MIN_DT = 6'h10;

endpackage

`default_nettype wire
